/* branchResolver.sv */
`timescale 1ns/1ns
`default_nettype none

module branchResolver (
    input  logic                           clk,
    input  logic                           rst,
    input  decodePkg::targetSelT           targetSel,
    input  logic [decodePkg::dataWidth-1:0] inst,
    input  logic [decodePkg::dataWidth-1:0] pcPlus2,
    input  logic [decodePkg::dataWidth-1:0] rs,
    output logic                           branch,
    output logic [decodePkg::dataWidth-1:0] pcBranch
);
    import decodePkg::*;

    logic [dataWidth-1:0] imm8;
    logic [dataWidth-1:0] disp11;
    logic [dataWidth-1:0] epc;
    logic                 rsZero;
    logic                 rsNeg;
    logic                 condTaken;

    assign imm8   = {{(dataWidth-8){inst[7]}}, inst[7:0]};
    assign disp11 = {{(dataWidth-11){inst[10]}}, inst[10:0]};

    assign rsZero = (rs == '0);
    assign rsNeg  = rs[dataWidth-1];

    // Condition code sits in the low opcode bits
    always_comb begin
        case (inst[12:11])
            2'b00:   condTaken = rsZero;
            2'b01:   condTaken = !rsZero;
            2'b10:   condTaken = rsNeg;
            default: condTaken = !rsNeg;
        endcase
    end

    always_comb begin
        branch   = 1'b0;
        pcBranch = pcPlus2;
        case (targetSel)
            TGT_COND: begin
                branch   = condTaken;
                pcBranch = pcPlus2 + imm8;
            end
            TGT_PCREL: begin
                branch   = 1'b1;
                pcBranch = pcPlus2 + disp11;
            end
            TGT_REGREL: begin
                branch   = 1'b1;
                pcBranch = rs + imm8;
            end
            TGT_TRAP: begin
                branch   = 1'b1;
                pcBranch = trapVector;
            end
            TGT_RTI: begin
                branch   = 1'b1;
                pcBranch = epc;
            end
            default: begin
                branch   = 1'b0;
                pcBranch = pcPlus2;
            end
        endcase
    end

    // Return address for RTI
    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= '0;
        end else if (targetSel == TGT_TRAP) begin
            epc <= pcPlus2;
        end
    end

endmodule

`default_nettype wire

/* controlDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
    input  logic [4:0]           opcode,
    output logic                 RegWrite,
    output logic                 DMemWrite,
    output logic                 DMemEn,
    output logic                 MemToReg,
    output logic                 DMemDump,
    output logic                 err,
    output decodePkg::regDstT    regDst,
    output decodePkg::targetSelT targetSel
);
    import decodePkg::*;

    always_comb begin
        // Inactive values unless an opcode overrides them
        RegWrite  = 1'b0;
        DMemWrite = 1'b0;
        DMemEn    = 1'b0;
        MemToReg  = 1'b0;
        DMemDump  = 1'b0;
        err       = 1'b0;
        regDst    = DST_RT;
        targetSel = TGT_NONE;

        case (opcodeT'(opcode))
            HALT: begin
                DMemDump = 1'b1;
            end
            NOP: begin
            end
            SIIC: begin
                targetSel = TGT_TRAP;
            end
            RTI: begin
                targetSel = TGT_RTI;
            end
            J: begin
                targetSel = TGT_PCREL;
            end
            JR: begin
                targetSel = TGT_REGREL;
            end
            // Link into r7
            JAL: begin
                RegWrite  = 1'b1;
                regDst    = DST_R7;
                targetSel = TGT_PCREL;
            end
            JALR: begin
                RegWrite  = 1'b1;
                regDst    = DST_R7;
                targetSel = TGT_REGREL;
            end
            ADDI, SUBI, XORI, ANDNI: begin
                RegWrite = 1'b1;
                regDst   = DST_RT;
            end
            BEQZ, BNEZ, BLTZ, BGEZ: begin
                targetSel = TGT_COND;
            end
            ST: begin
                DMemEn    = 1'b1;
                DMemWrite = 1'b1;
            end
            LD: begin
                DMemEn   = 1'b1;
                MemToReg = 1'b1;
                RegWrite = 1'b1;
                regDst   = DST_RT;
            end
            // Store with base register update
            STU: begin
                DMemEn    = 1'b1;
                DMemWrite = 1'b1;
                RegWrite  = 1'b1;
                regDst    = DST_RS;
            end
            LBI: begin
                RegWrite = 1'b1;
                regDst   = DST_RS;
            end
            ALUR: begin
                RegWrite = 1'b1;
                regDst   = DST_RD;
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* decodePkg.sv */
`default_nettype none

package decodePkg;

    // Datapath sizes
    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 3;
    localparam int numRegs      = 8;

    // Handler entry for the illegal-instruction trap
    localparam logic [dataWidth-1:0] trapVector = 16'h0002;

    // Opcode field in InstIn[15:11]
    typedef enum logic [4:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        SIIC  = 5'b00010,
        RTI   = 5'b00011,
        J     = 5'b00100,
        JR    = 5'b00101,
        JAL   = 5'b00110,
        JALR  = 5'b00111,
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        BEQZ  = 5'b01100,
        BNEZ  = 5'b01101,
        BLTZ  = 5'b01110,
        BGEZ  = 5'b01111,
        ST    = 5'b10000,
        LD    = 5'b10001,
        STU   = 5'b10011,
        LBI   = 5'b11000,
        ALUR  = 5'b11011
    } opcodeT;

    // Source of the destination register address
    typedef enum logic [1:0] {
        DST_RT,
        DST_RD,
        DST_RS,
        DST_R7
    } regDstT;

    // Kind of control transfer
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_COND,
        TGT_PCREL,
        TGT_REGREL,
        TGT_TRAP,
        TGT_RTI
    } targetSelT;

endpackage

`default_nettype wire

/* decodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [decodePkg::dataWidth-1:0]    InstIn,
    input  logic [decodePkg::dataWidth-1:0]    pcPlus2In,
    input  logic [decodePkg::dataWidth-1:0]    wbWriteData,
    input  logic                              wbRegWrite,
    input  logic [decodePkg::regAddrWidth-1:0] wbRdAddr,
    output logic [decodePkg::dataWidth-1:0]    InstOut,
    output logic [decodePkg::dataWidth-1:0]    pcPlus2Out,
    output logic [decodePkg::dataWidth-1:0]    Rs,
    output logic [decodePkg::dataWidth-1:0]    Rt,
    output logic                              RegWrite,
    output logic                              DMemWrite,
    output logic                              DMemEn,
    output logic                              MemToReg,
    output logic                              DMemDump,
    output logic [decodePkg::regAddrWidth-1:0] RdAddr,
    output logic [decodePkg::dataWidth-1:0]    pcBranch,
    output logic                              branch,
    output logic                              err
);
    import decodePkg::*;

    logic [4:0]              opcode;
    logic [regAddrWidth-1:0] rsSel;
    logic [regAddrWidth-1:0] rtSel;
    logic [regAddrWidth-1:0] rdSel;
    regDstT                  regDst;
    targetSelT               targetSel;

    // Instruction fields
    assign opcode = InstIn[15:11];
    assign rsSel  = InstIn[10:8];
    assign rtSel  = InstIn[7:5];
    assign rdSel  = InstIn[4:2];

    assign InstOut    = InstIn;
    assign pcPlus2Out = pcPlus2In;

    controlDecoder ctrl (
        .opcode    (opcode),
        .RegWrite  (RegWrite),
        .DMemWrite (DMemWrite),
        .DMemEn    (DMemEn),
        .MemToReg  (MemToReg),
        .DMemDump  (DMemDump),
        .err       (err),
        .regDst    (regDst),
        .targetSel (targetSel)
    );

    registerFile regFile (
        .clk       (clk),
        .rst       (rst),
        .readSel1  (rsSel),
        .readSel2  (rtSel),
        .writeSel  (wbRdAddr),
        .writeData (wbWriteData),
        .writeEn   (wbRegWrite),
        .readData1 (Rs),
        .readData2 (Rt)
    );

    always_comb begin
        case (regDst)
            DST_RT: RdAddr = rtSel;
            DST_RD: RdAddr = rdSel;
            DST_RS: RdAddr = rsSel;
            DST_R7: RdAddr = regAddrWidth'(numRegs - 1);
        endcase
    end

    branchResolver resolver (
        .clk       (clk),
        .rst       (rst),
        .targetSel (targetSel),
        .inst      (InstIn),
        .pcPlus2   (pcPlus2In),
        .rs        (Rs),
        .branch    (branch),
        .pcBranch  (pcBranch)
    );

endmodule

`default_nettype wire

/* decodeStage_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage_checker (
    input logic                            clk,
    input logic                            rst,
    input logic [decodePkg::dataWidth-1:0] InstIn,
    input logic [decodePkg::dataWidth-1:0] pcPlus2In,
    input logic [decodePkg::dataWidth-1:0] pcBranch,
    input logic                            branch,
    input logic                            err,
    input logic                            RegWrite,
    input logic                            DMemEn,
    input logic                            DMemWrite
);
    import decodePkg::*;

    logic [dataWidth-1:0] savedPc;

    // Shadow of the exception pc
    always_ff @(posedge clk) begin
        if (rst) begin
            savedPc <= '0;
        end else if (InstIn[15:11] == SIIC) begin
            savedPc <= pcPlus2In;
        end
    end

    errQuiet: assert property (@(posedge clk) disable iff (rst)
        err |-> !RegWrite && !DMemEn && !branch)
        else $error("err raised with RegWrite, DMemEn or branch active");

    storeEnabled: assert property (@(posedge clk) disable iff (rst) DMemWrite |-> DMemEn)
        else $error("DMemWrite high while DMemEn low");

    rtiReturn: assert property (@(posedge clk) disable iff (rst)
        (InstIn[15:11] == RTI) |-> (pcBranch == savedPc))
        else $error("RTI target differs from the pc saved by SIIC");

endmodule

bind decodeStage decodeStage_checker chk (.*);

`default_nettype wire

/* registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [decodePkg::regAddrWidth-1:0] readSel1,
    input  logic [decodePkg::regAddrWidth-1:0] readSel2,
    input  logic [decodePkg::regAddrWidth-1:0] writeSel,
    input  logic [decodePkg::dataWidth-1:0]    writeData,
    input  logic                              writeEn,
    output logic [decodePkg::dataWidth-1:0]    readData1,
    output logic [decodePkg::dataWidth-1:0]    readData2
);
    import decodePkg::*;

    logic [dataWidth-1:0] regs [numRegs];

    logic bypass1;
    logic bypass2;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Write-through so a same-cycle write-back is seen by decode
    assign bypass1 = writeEn && (writeSel == readSel1);
    assign bypass2 = writeEn && (writeSel == readSel2);

    assign readData1 = bypass1 ? writeData : regs[readSel1];
    assign readData2 = bypass2 ? writeData : regs[readSel2];

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbDecodeStage -f vlog.f -o simDecodeStage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simDecodeStage > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0

/* tbDecodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module tbDecodeStage;
    import decodePkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        wbRegWrite;
    logic [2:0]  wbRdAddr;
    logic [2:0]  RdAddr;
    logic [15:0] InstIn;
    logic [15:0] pcPlus2In;
    logic [15:0] wbWriteData;
    logic [15:0] InstOut;
    logic [15:0] pcPlus2Out;
    logic [15:0] Rs;
    logic [15:0] Rt;
    logic [15:0] pcBranch;
    logic        RegWrite;
    logic        DMemWrite;
    logic        DMemEn;
    logic        MemToReg;
    logic        DMemDump;
    logic        branch;
    logic        err;

    // Reference model of the register file and exception pc
    logic [15:0] regModel [8];
    logic [15:0] epcModel;
    integer      seed = 32'h9e1b_4093;
    int          errors = 0;
    int          errorsAtStart = 0;
    int          passCount = 0;
    int          failCount = 0;

    decodeStage DUT (.*);

    always #2 clk = ~clk;

    function automatic logic [15:0] readModel(input logic [2:0] sel);
        return (wbRegWrite && wbRdAddr == sel) ? wbWriteData : regModel[sel];
    endfunction

    // {RegWrite, DMemWrite, DMemEn, MemToReg, DMemDump, err}
    function automatic logic [5:0] ctrlModel(input logic [4:0] op);
        case (op)
            ADDI, SUBI, XORI, ANDNI, LBI, ALUR, JAL, JALR: return 6'b100000;
            LD:      return 6'b101100;
            ST:      return 6'b011000;
            STU:     return 6'b111000;
            HALT:    return 6'b000010;
            NOP, SIIC, RTI, J, JR, BEQZ, BNEZ, BLTZ, BGEZ: return 6'b000000;
            default: return 6'b000001;
        endcase
    endfunction

    function automatic logic [2:0] dstModel(input logic [15:0] inst);
        case (inst[15:11])
            ALUR:      return inst[4:2];
            LBI, STU:  return inst[10:8];
            JAL, JALR: return 3'd7;
            default:   return inst[7:5];
        endcase
    endfunction

    // {branch, pcBranch}
    function automatic logic [16:0] branchModel(input logic [15:0] inst, pc, rsVal);
        logic [15:0] imm8;
        logic [15:0] disp11;
        imm8   = {{8{inst[7]}}, inst[7:0]};
        disp11 = {{5{inst[10]}}, inst[10:0]};
        case (inst[15:11])
            BEQZ:     return {rsVal == 16'h0, pc + imm8};
            BNEZ:     return {rsVal != 16'h0, pc + imm8};
            BLTZ:     return {rsVal[15], pc + imm8};
            BGEZ:     return {~rsVal[15], pc + imm8};
            J, JAL:   return {1'b1, pc + disp11};
            JR, JALR: return {1'b1, rsVal + imm8};
            SIIC:     return {1'b1, trapVector};
            RTI:      return {1'b1, epcModel};
            default:  return 17'h0;
        endcase
    endfunction

    task automatic expectEq(input string name, input logic [15:0] exp, act);
        assert (act === exp) else begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Drives one instruction and checks it just before the next edge
    task automatic step(input logic [15:0] inst, pc, input logic wbEn,
                        input logic [2:0] wbAddr, input logic [15:0] wbData);
        logic [5:0]  ctrl;
        logic [16:0] br;
        @(posedge clk);
        #1;
        InstIn      = inst;
        pcPlus2In   = pc;
        wbRegWrite  = wbEn;
        wbRdAddr    = wbAddr;
        wbWriteData = wbData;
        #2;
        ctrl = ctrlModel(inst[15:11]);
        br   = branchModel(inst, pc, readModel(inst[10:8]));
        expectEq("Rs", readModel(inst[10:8]), Rs);
        expectEq("Rt", readModel(inst[7:5]), Rt);
        expectEq("InstOut", inst, InstOut);
        expectEq("pcPlus2Out", pc, pcPlus2Out);
        expectEq("{RegWrite,DMemWrite,DMemEn,MemToReg,DMemDump,err}", 16'(ctrl),
                 16'({RegWrite, DMemWrite, DMemEn, MemToReg, DMemDump, err}));
        expectEq("branch", 16'(br[16]), 16'(branch));
        if (br[16])
            expectEq("pcBranch", br[15:0], pcBranch);
        if (ctrl[5])
            expectEq("RdAddr", 16'(dstModel(inst)), 16'(RdAddr));
        // Commits at the coming edge
        if (wbEn)
            regModel[wbAddr] = wbData;
        if (inst[15:11] == SIIC)
            epcModel = pc;
    endtask

    task automatic sweepOpcodes(input logic undefinedOnly);
        logic [5:0] ctrl;
        for (int code = 0; code < 32; code++) begin
            ctrl = ctrlModel(5'(code));
            if (ctrl[0] == undefinedOnly)
                step({5'(code), 11'($random(seed))}, 16'h0200, 1'b0, 3'h0, 16'h0);
        end
    endtask

    task automatic finishTest(input string name);
        $display("Test %s done with %0d errors", name, errors - errorsAtStart);
        if (errors == errorsAtStart)
            passCount++;
        else
            failCount++;
        errorsAtStart = errors;
    endtask

    task automatic runTests();
        opcodeT condOps [4] = '{BEQZ, BNEZ, BLTZ, BGEZ};
        opcodeT jumpOps [4] = '{J, JAL, JR, JALR};
        // Same-cycle write and read goes through the bypass
        for (int i = 0; i < 8; i++)
            step({NOP, 3'(i), 3'(i), 5'h0}, 16'h0100, 1'b1, 3'(i), 16'($random(seed)));
        for (int i = 0; i < 8; i++)
            step({NOP, 3'(i), 3'(7 - i), 5'h0}, 16'h0100, 1'b0, 3'h0, 16'h0);
        finishTest("register write and read");
        sweepOpcodes(1'b0);
        finishTest("control and destination");
        // r1 zero, r2 positive, r3 negative
        step({NOP, 11'h0}, 16'h0100, 1'b1, 3'd1, 16'h0);
        step({NOP, 11'h0}, 16'h0100, 1'b1, 3'd2, (16'($random(seed)) & 16'h7fff) | 16'h1);
        step({NOP, 11'h0}, 16'h0100, 1'b1, 3'd3, 16'($random(seed)) | 16'h8000);
        foreach (condOps[k]) begin
            for (int r = 1; r < 4; r++) begin
                step({condOps[k], 3'(r), 8'h3c}, 16'($random(seed)) & 16'hfffe, 1'b0, 3'h0, 16'h0);
                step({condOps[k], 3'(r), 8'hc4}, 16'($random(seed)) & 16'hfffe, 1'b0, 3'h0, 16'h0);
            end
        end
        finishTest("conditional branches");
        // Field 234 reads r2 with positive offsets and 7c8 reads r7 with negative ones
        foreach (jumpOps[k]) begin
            step({jumpOps[k], 11'h234}, 16'h2000, 1'b0, 3'h0, 16'h0);
            step({jumpOps[k], 11'h7c8}, 16'h2000, 1'b0, 3'h0, 16'h0);
        end
        finishTest("jumps");
        step({SIIC, 11'h0}, 16'h4a5e, 1'b0, 3'h0, 16'h0);
        step({NOP, 11'h0}, 16'h4a60, 1'b0, 3'h0, 16'h0);
        step({RTI, 11'h0}, 16'h0040, 1'b0, 3'h0, 16'h0);
        finishTest("trap and return");
        sweepOpcodes(1'b1);
        finishTest("undefined opcodes");
    endtask

    initial begin
        int waited;
        rst         = 1'b1;
        InstIn      = {NOP, 11'h0};
        pcPlus2In   = 16'h0;
        wbWriteData = 16'h0;
        wbRegWrite  = 1'b0;
        wbRdAddr    = 3'h0;
        epcModel    = 16'h0;
        for (int i = 0; i < 8; i++)
            regModel[i] = 16'h0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        waited = 0;
        while (Rs !== 16'h0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (Rs !== 16'h0) begin
            $display("Timeout waiting for the register file to clear after reset");
            errors++;
            failCount++;
        end else begin
            runTests();
        end
        $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
decodePkg.sv
controlDecoder.sv
registerFile.sv
branchResolver.sv
decodeStage.sv
decodeStage_checker.sv
tbDecodeStage.sv
